// ==== bench/tb_clk_gen.sv ====
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;   // 4 ns period
  end

  // reset held for 10 rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end
endmodule

// ==== bench/tb_id_stage.sv ====
`include "id_defs.svh"

module tb_id_stage;
  timeunit 1ns;
  timeprecision 100ps;

  logic clk, rst_n;
  logic instr_valid, deassert_we, jump_mux, branch_mux;
  id_pkg::instr_t instr_rdata;
  logic illegal_insn, ebrk_insn, mret_insn, ecall_insn, pipe_flush;
  logic regfile_we, data_req, data_we, data_sign_ext, jump_in_id, branch_in_id;
  id_pkg::alu_op_t alu_operator;
  id_pkg::op_sel_t op_a_sel, op_b_sel;
  id_pkg::imm_sel_t imm_b_sel;
  id_pkg::data_type_t data_type;

  tb_clk_gen i_clk_gen (.clk_o (clk), .rst_n_o (rst_n));

  id_stage i_dut (
    .clk_i (clk), .rst_n_i (rst_n), .instr_valid_i (instr_valid),
    .instr_rdata_i (instr_rdata), .deassert_we_i (deassert_we),
    .jump_mux_i (jump_mux), .branch_mux_i (branch_mux),
    .illegal_insn_o (illegal_insn), .ebrk_insn_o (ebrk_insn), .mret_insn_o (mret_insn),
    .ecall_insn_o (ecall_insn), .pipe_flush_o (pipe_flush), .alu_operator_o (alu_operator),
    .alu_op_a_mux_sel_o (op_a_sel), .alu_op_b_mux_sel_o (op_b_sel),
    .imm_b_mux_sel_o (imm_b_sel), .regfile_we_o (regfile_we), .data_req_o (data_req),
    .data_we_o (data_we), .data_type_o (data_type),
    .data_sign_extension_o (data_sign_ext), .jump_in_id_o (jump_in_id),
    .branch_in_id_o (branch_in_id)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      stop_run();
    end
  endtask

  // all verdict and side-effect outputs at once
  task automatic expect_ctrl(input logic ill, we, req, dwe, jmp, br, ec, eb, mr, fl);
    compare_value("illegal_insn_o", 32'(illegal_insn), 32'(ill));
    compare_value("regfile_we_o", 32'(regfile_we), 32'(we));
    compare_value("data_req_o", 32'(data_req), 32'(req));
    compare_value("data_we_o", 32'(data_we), 32'(dwe));
    compare_value("jump_in_id_o", 32'(jump_in_id), 32'(jmp));
    compare_value("branch_in_id_o", 32'(branch_in_id), 32'(br));
    compare_value("ecall_insn_o", 32'(ecall_insn), 32'(ec));
    compare_value("ebrk_insn_o", 32'(ebrk_insn), 32'(eb));
    compare_value("mret_insn_o", 32'(mret_insn), 32'(mr));
    compare_value("pipe_flush_o", 32'(pipe_flush), 32'(fl));
  endtask

  task automatic expect_sels(input logic [2:0] opa, opb, input logic [3:0] immb);
    compare_value("alu_op_a_mux_sel_o", 32'(op_a_sel), 32'(opa));
    compare_value("alu_op_b_mux_sel_o", 32'(op_b_sel), 32'(opb));
    compare_value("imm_b_mux_sel_o", 32'(imm_b_sel), 32'(immb));
  endtask

  // r-type field layout that other formats reuse for imm bits
  function automatic id_pkg::instr_t encode(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
      input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic id_pkg::instr_t rand_fields(input logic [2:0] f3, input logic [6:0] opc);
    return encode(7'($urandom), 5'($urandom), 5'($urandom), f3, 5'($urandom), opc);
  endfunction

  // strobe on a falling edge and decode in the cycle after the rising edge
  task automatic send_instr(input id_pkg::instr_t word, input logic jm, bm, stall);
    @(negedge clk);
    instr_valid = 1'b1;
    instr_rdata = word;
    jump_mux    = jm;
    branch_mux  = bm;
    @(posedge clk);
    @(negedge clk);
    instr_valid = 1'b0;
    deassert_we = stall;
    #1;                          // settle the decode mid low phase
  endtask

  task automatic decode_sys(input id_pkg::instr_t word, input logic ill, ec, eb, mr, fl);
    send_instr(word, 1'b0, 1'b0, 1'b0);
    expect_ctrl(ill, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, ec, eb, mr, fl);
  endtask

  // legal word held under stall and then released
  task automatic hold_in_stall(input id_pkg::instr_t word, input logic we, req, dwe);
    send_instr(word, 1'b0, 1'b0, 1'b1);
    expect_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    @(negedge clk);
    #1;
    expect_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    @(negedge clk);
    deassert_we = 1'b0;
    #1;
    expect_ctrl(1'b0, we, req, dwe, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////
  initial begin
    logic [2:0] f3;
    logic [6:0] f7;
    logic is_imm, is_store, legal, phase;
    logic [5:0] exp_op;

    instr_valid = 1'b0;
    instr_rdata = '0;
    deassert_we = 1'b0;
    jump_mux    = 1'b0;
    branch_mux  = 1'b0;
    void'($urandom(32'hd5fa));

    // quiet through reset and before the first strobe
    for (int t = 0; t < 40 && !rst_n; t++) begin
      @(negedge clk);
      #1;
      expect_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    if (!rst_n) begin
      $display("reset was not released within 40 cycles");
      stop_run();
    end
    repeat (3) begin
      @(negedge clk);
      #1;
      expect_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    end

    // random op and op-imm with funct7 biased to the two legal forms
    for (int n = 0; n < 60; n++) begin
      f3     = 3'($urandom);
      is_imm = 1'($urandom);
      case ($urandom % 3)
        0:       f7 = 7'b0000000;
        1:       f7 = 7'b0100000;
        default: f7 = 7'($urandom);
      endcase
      if (is_imm)
        legal = (f3 == 3'b001) ? (f7 == 7'd0) :
                (f3 == 3'b101) ? (f7 == 7'd0 || f7 == 7'b0100000) : 1'b1;
      else
        legal = (f7 == 7'd0) || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
      case (f3)
        3'b000:  exp_op = (!is_imm && f7[5]) ? `ID_ALU_SUB : `ID_ALU_ADD;
        3'b001:  exp_op = `ID_ALU_SLL;
        3'b010:  exp_op = `ID_ALU_SLTS;
        3'b011:  exp_op = `ID_ALU_SLTU;
        3'b100:  exp_op = `ID_ALU_XOR;
        3'b101:  exp_op = f7[5] ? `ID_ALU_SRA : `ID_ALU_SRL;
        3'b110:  exp_op = `ID_ALU_OR;
        default: exp_op = `ID_ALU_AND;
      endcase
      send_instr(encode(f7, 5'($urandom), 5'($urandom), f3, 5'($urandom),
                        is_imm ? `ID_OPC_OPIMM : `ID_OPC_OP), 1'b0, 1'b0, 1'b0);
      expect_ctrl(!legal, legal, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      if (legal)
        compare_value("alu_operator_o", 32'(alu_operator), 32'(exp_op));
      expect_sels(`ID_OPA_REGA, is_imm ? `ID_OPB_IMM : `ID_OPB_REGB, `ID_IMMB_I);
    end
    send_instr(rand_fields(3'($urandom), `ID_OPC_LUI), 1'b0, 1'b0, 1'b0);
    expect_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    expect_sels(`ID_OPA_IMM, `ID_OPB_IMM, `ID_IMMB_U);    // 0 + upper imm
    send_instr(rand_fields(3'($urandom), `ID_OPC_AUIPC), 1'b0, 1'b0, 1'b0);
    expect_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    expect_sels(`ID_OPA_CURRPC, `ID_OPB_IMM, `ID_IMMB_U);

    // every funct3 for loads and stores
    for (int k = 0; k < 16; k++) begin
      is_store = (k >= 8);
      f3       = 3'(k);
      legal    = is_store ? (f3 <= 3'b010) : (f3 != 3'b011 && f3[2:1] != 2'b11);
      send_instr(rand_fields(f3, is_store ? `ID_OPC_STORE : `ID_OPC_LOAD), 1'b0, 1'b0, 1'b0);
      expect_ctrl(!legal, legal & !is_store, legal, legal & is_store,
                  1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      compare_value("data_sign_extension_o", 32'(data_sign_ext), 32'(!is_store && !f3[2]));
      if (legal)
        compare_value("data_type_o", 32'(data_type), (f3[1:0] == 2'b00) ? 32'(`ID_DT_BYTE) :
                      (f3[1:0] == 2'b01) ? 32'(`ID_DT_HALF) : 32'(`ID_DT_WORD));
      expect_sels(`ID_OPA_REGA, `ID_OPB_IMM, is_store ? `ID_IMMB_S : `ID_IMMB_I);
    end

    // jumps and branches in phase 1 then phase 0
    for (int p = 1; p >= 0; p--) begin
      phase = 1'(p);
      send_instr(rand_fields(3'($urandom), `ID_OPC_JAL), phase, 1'b0, 1'b0);
      expect_ctrl(1'b0, !phase, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      expect_sels(`ID_OPA_CURRPC, `ID_OPB_IMM, phase ? `ID_IMMB_UJ : `ID_IMMB_PCINCR);
      send_instr(rand_fields(3'b000, `ID_OPC_JALR), phase, 1'b0, 1'b0);
      expect_ctrl(1'b0, !phase, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      expect_sels(phase ? `ID_OPA_REGA : `ID_OPA_CURRPC, `ID_OPB_IMM,
                  phase ? `ID_IMMB_I : `ID_IMMB_PCINCR);
      send_instr(rand_fields(3'(1 + $urandom % 7), `ID_OPC_JALR), phase, 1'b0, 1'b0);
      expect_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      for (int b = 0; b < 8; b++) begin
        f3    = 3'(b);
        legal = (f3[2:1] != 2'b01);
        case (f3)
          3'b000:  exp_op = `ID_ALU_EQ;
          3'b001:  exp_op = `ID_ALU_NE;
          3'b100:  exp_op = `ID_ALU_LTS;
          3'b101:  exp_op = `ID_ALU_GES;
          3'b110:  exp_op = `ID_ALU_LTU;
          default: exp_op = `ID_ALU_GEU;
        endcase
        send_instr(rand_fields(f3, `ID_OPC_BRANCH), 1'b0, phase, 1'b0);
        expect_ctrl(!legal, 1'b0, 1'b0, 1'b0, 1'b0, legal, 1'b0, 1'b0, 1'b0, 1'b0);
        if (phase) begin
          expect_sels(`ID_OPA_REGA, `ID_OPB_REGB, `ID_IMMB_I);
          if (legal)
            compare_value("alu_operator_o", 32'(alu_operator), 32'(exp_op));
        end else begin
          expect_sels(`ID_OPA_CURRPC, `ID_OPB_IMM, `ID_IMMB_SB);
          compare_value("alu_operator_o", 32'(alu_operator), 32'(`ID_ALU_ADD));
        end
      end
    end

    // system, fence and unknown opcodes
    decode_sys({`ID_SYS_ECALL, 13'h0, `ID_OPC_SYSTEM}, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    decode_sys({`ID_SYS_EBREAK, 13'h0, `ID_OPC_SYSTEM}, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    decode_sys({`ID_SYS_MRET, 13'h0, `ID_OPC_SYSTEM}, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    decode_sys({`ID_SYS_WFI, 13'h0, `ID_OPC_SYSTEM}, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    decode_sys({12'h002, 13'h0, `ID_OPC_SYSTEM}, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    decode_sys(rand_fields(3'b001, `ID_OPC_SYSTEM), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);  // csrrw
    decode_sys(encode(7'h07, 5'h1f, 5'h0, 3'b000, 5'h0, `ID_OPC_FENCE),
               1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    decode_sys(encode(7'h0, 5'h0, 5'h0, 3'b001, 5'h0, `ID_OPC_FENCE),
               1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    decode_sys(rand_fields(3'b010, `ID_OPC_FENCE), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    decode_sys(rand_fields(3'($urandom), 7'h0b), 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    decode_sys(32'h0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);

    // stall masks a legal add and a legal sw
    hold_in_stall(encode(7'h0, 5'd3, 5'd2, 3'b000, 5'd1, `ID_OPC_OP), 1'b1, 1'b0, 1'b0);
    hold_in_stall(rand_fields(3'b010, `ID_OPC_STORE), 1'b0, 1'b1, 1'b1);

    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/100ps \
  -f vlog.f --top-module tb_id_stage -o sim_id_stage
# $fatal gives a nonzero exit status, so set -e stops here on failure
./obj_dir/sim_id_stage

// ==== source/alu_decoder.sv ====
`include "id_defs.svh"

module alu_decoder (
  input  id_pkg::instr_t   instr_i,
  input  logic             jump_mux_i,       // 1: target phase
  input  logic             branch_mux_i,     // 1: compare phase
  output id_pkg::alu_op_t  alu_operator_o,
  output id_pkg::op_sel_t  alu_op_a_mux_sel_o,
  output id_pkg::op_sel_t  alu_op_b_mux_sel_o,
  output id_pkg::imm_sel_t imm_b_mux_sel_o,
  output logic             regfile_we_o,     // raw, gated later
  output logic             jump_o,
  output logic             branch_o,
  output logic             hit_o,
  output logic             illegal_o
);

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = instr_i[`ID_F3_RANGE];
  assign funct7 = instr_i[`ID_F7_RANGE];

  always_comb begin
    alu_operator_o     = `ID_ALU_ADD;
    alu_op_a_mux_sel_o = `ID_OPA_REGA;
    alu_op_b_mux_sel_o = `ID_OPB_REGB;
    imm_b_mux_sel_o    = `ID_IMMB_I;
    regfile_we_o       = 1'b0;
    jump_o             = 1'b0;
    branch_o           = 1'b0;
    hit_o              = 1'b1;   // cleared in default arm
    illegal_o          = 1'b0;

    case (instr_i[`ID_OPC_RANGE])
      ////////////////////////////
      // jumps and branches
      ////////////////////////////
      `ID_OPC_JAL, `ID_OPC_JALR: begin
        jump_o             = 1'b1;
        alu_op_b_mux_sel_o = `ID_OPB_IMM;
        if (jump_mux_i) begin        // target: pc+uj or rs1+i
          if (instr_i[`ID_OPC_RANGE] == `ID_OPC_JAL) begin
            alu_op_a_mux_sel_o = `ID_OPA_CURRPC;
            imm_b_mux_sel_o    = `ID_IMMB_UJ;
          end
        end else begin               // link value pc+4
          alu_op_a_mux_sel_o = `ID_OPA_CURRPC;
          imm_b_mux_sel_o    = `ID_IMMB_PCINCR;
          regfile_we_o       = 1'b1;
        end
        if (instr_i[`ID_OPC_RANGE] == `ID_OPC_JALR && funct3 != 3'b000)
          illegal_o = 1'b1;
      end

      `ID_OPC_BRANCH: begin
        branch_o = 1'b1;
        if (branch_mux_i) begin
          case (funct3)              // rs1 vs rs2 compare
            3'b000:  alu_operator_o = `ID_ALU_EQ;
            3'b001:  alu_operator_o = `ID_ALU_NE;
            3'b100:  alu_operator_o = `ID_ALU_LTS;
            3'b101:  alu_operator_o = `ID_ALU_GES;
            3'b110:  alu_operator_o = `ID_ALU_LTU;
            3'b111:  alu_operator_o = `ID_ALU_GEU;
            default: alu_operator_o = `ID_ALU_ADD;
          endcase
        end else begin               // target pc+sb
          alu_op_a_mux_sel_o = `ID_OPA_CURRPC;
          alu_op_b_mux_sel_o = `ID_OPB_IMM;
          imm_b_mux_sel_o    = `ID_IMMB_SB;
        end
        illegal_o = (funct3[2:1] == 2'b01);   // 010, 011 unused
      end

      ////////////////////////////
      // alu
      ////////////////////////////
      `ID_OPC_LUI, `ID_OPC_AUIPC: begin
        alu_op_a_mux_sel_o = (instr_i[5]) ? `ID_OPA_IMM : `ID_OPA_CURRPC;  // lui: 0+u
        alu_op_b_mux_sel_o = `ID_OPB_IMM;
        imm_b_mux_sel_o    = `ID_IMMB_U;
        regfile_we_o       = 1'b1;
      end

      `ID_OPC_OPIMM: begin
        alu_op_b_mux_sel_o = `ID_OPB_IMM;
        regfile_we_o       = 1'b1;
        case (funct3)
          3'b000: alu_operator_o = `ID_ALU_ADD;
          3'b010: alu_operator_o = `ID_ALU_SLTS;
          3'b011: alu_operator_o = `ID_ALU_SLTU;
          3'b100: alu_operator_o = `ID_ALU_XOR;
          3'b110: alu_operator_o = `ID_ALU_OR;
          3'b111: alu_operator_o = `ID_ALU_AND;
          3'b001: begin
            alu_operator_o = `ID_ALU_SLL;
            illegal_o      = (funct7 != 7'b0000000);
          end
          default: begin             // 101, shamt shifts right
            alu_operator_o = (funct7[5]) ? `ID_ALU_SRA : `ID_ALU_SRL;
            illegal_o      = ({funct7[6], funct7[4:0]} != 6'b000000);
          end
        endcase
      end

      `ID_OPC_OP: begin
        regfile_we_o = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_operator_o = `ID_ALU_ADD;
          {7'b0100000, 3'b000}: alu_operator_o = `ID_ALU_SUB;
          {7'b0000000, 3'b010}: alu_operator_o = `ID_ALU_SLTS;
          {7'b0000000, 3'b011}: alu_operator_o = `ID_ALU_SLTU;
          {7'b0000000, 3'b100}: alu_operator_o = `ID_ALU_XOR;
          {7'b0000000, 3'b110}: alu_operator_o = `ID_ALU_OR;
          {7'b0000000, 3'b111}: alu_operator_o = `ID_ALU_AND;
          {7'b0000000, 3'b001}: alu_operator_o = `ID_ALU_SLL;
          {7'b0000000, 3'b101}: alu_operator_o = `ID_ALU_SRL;
          {7'b0100000, 3'b101}: alu_operator_o = `ID_ALU_SRA;
          default:              illegal_o      = 1'b1;   // incl. rv32m
        endcase
      end

      default: hit_o = 1'b0;         // not an alu/flow opcode
    endcase
  end

endmodule

// ==== source/id_ctrl_gate.sv ====
`include "id_defs.svh"

module id_ctrl_gate (
  input  logic             valid_i,
  input  logic             deassert_we_i,
  input  logic             alu_hit_i,
  input  logic             alu_illegal_i,
  input  logic             lsu_hit_i,
  input  logic             lsu_illegal_i,
  input  logic             sys_hit_i,
  input  logic             sys_illegal_i,
  input  logic             alu_regfile_we_i,
  input  logic             lsu_regfile_we_i,
  input  logic             data_req_i,
  input  logic             data_we_i,
  input  logic             jump_i,
  input  logic             branch_i,
  input  logic             ecall_i,
  input  logic             ebrk_i,
  input  logic             mret_i,
  input  logic             pipe_flush_i,
  input  id_pkg::op_sel_t  alu_op_b_sel_i,
  input  id_pkg::imm_sel_t alu_imm_b_sel_i,
  input  id_pkg::imm_sel_t lsu_imm_b_sel_i,
  output logic             illegal_insn_o,
  output logic             regfile_we_o,
  output logic             data_req_o,
  output logic             data_we_o,
  output logic             jump_in_id_o,
  output logic             branch_in_id_o,
  output logic             ecall_insn_o,
  output logic             ebrk_insn_o,
  output logic             mret_insn_o,
  output logic             pipe_flush_o,
  output id_pkg::op_sel_t  alu_op_b_mux_sel_o,
  output id_pkg::imm_sel_t imm_b_mux_sel_o
);

  logic any_hit;
  logic any_illegal;
  logic side_en;     // side effects allowed this cycle

  assign any_hit     = alu_hit_i | lsu_hit_i | sys_hit_i;
  assign any_illegal = alu_illegal_i | lsu_illegal_i | sys_illegal_i;

  assign illegal_insn_o = valid_i & (~any_hit | any_illegal);
  assign side_en        = valid_i & ~deassert_we_i & ~illegal_insn_o;

  //////////////////////////////
  // masked side effects
  //////////////////////////////
  assign regfile_we_o   = side_en & (alu_regfile_we_i | lsu_regfile_we_i);
  assign data_req_o     = side_en & data_req_i;
  assign data_we_o      = side_en & data_we_i;
  assign jump_in_id_o   = side_en & jump_i;
  assign branch_in_id_o = side_en & branch_i;
  assign ecall_insn_o   = side_en & ecall_i;
  assign ebrk_insn_o    = side_en & ebrk_i;
  assign mret_insn_o    = side_en & mret_i;
  assign pipe_flush_o   = side_en & pipe_flush_i;

  // load/store address is rs1 + imm, alu decoder idles at add/rega
  assign alu_op_b_mux_sel_o = (lsu_hit_i) ? `ID_OPB_IMM : alu_op_b_sel_i;
  assign imm_b_mux_sel_o    = (lsu_hit_i) ? lsu_imm_b_sel_i : alu_imm_b_sel_i;

endmodule

// ==== source/id_defs.svh ====
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// instruction field slices
`define ID_OPC_RANGE 6:0
`define ID_F3_RANGE 14:12
`define ID_F7_RANGE 31:25
`define ID_F12_RANGE 31:20

// major opcodes
`define ID_OPC_LOAD 7'h03
`define ID_OPC_FENCE 7'h0f
`define ID_OPC_OPIMM 7'h13
`define ID_OPC_AUIPC 7'h17
`define ID_OPC_STORE 7'h23
`define ID_OPC_OP 7'h33
`define ID_OPC_LUI 7'h37
`define ID_OPC_BRANCH 7'h63
`define ID_OPC_JALR 7'h67
`define ID_OPC_JAL 7'h6f
`define ID_OPC_SYSTEM 7'h73

// alu operators
`define ID_ALU_ADD 6'b011000
`define ID_ALU_SUB 6'b011001
`define ID_ALU_XOR 6'b101111
`define ID_ALU_OR 6'b101110
`define ID_ALU_AND 6'b010101
`define ID_ALU_SRA 6'b100100
`define ID_ALU_SRL 6'b100101
`define ID_ALU_SLL 6'b100111
`define ID_ALU_LTS 6'b000000
`define ID_ALU_LTU 6'b000001
`define ID_ALU_GES 6'b001010
`define ID_ALU_GEU 6'b001011
`define ID_ALU_EQ 6'b001100
`define ID_ALU_NE 6'b001101
`define ID_ALU_SLTS 6'b000010
`define ID_ALU_SLTU 6'b000011

// operand selects
`define ID_OPA_REGA 3'b000
`define ID_OPA_CURRPC 3'b001
`define ID_OPA_IMM 3'b010
`define ID_OPB_REGB 3'b000
`define ID_OPB_IMM 3'b010

// immediate b selects
`define ID_IMMB_I 4'b0000
`define ID_IMMB_S 4'b0001
`define ID_IMMB_U 4'b0010
`define ID_IMMB_PCINCR 4'b0011
`define ID_IMMB_UJ 4'b1100
`define ID_IMMB_SB 4'b1101

// memory access size
`define ID_DT_WORD 2'b00
`define ID_DT_HALF 2'b01
`define ID_DT_BYTE 2'b10

// funct12 of non-csr system instructions
`define ID_SYS_ECALL 12'h000
`define ID_SYS_EBREAK 12'h001
`define ID_SYS_MRET 12'h302
`define ID_SYS_WFI 12'h105

`endif

// ==== source/id_pipe_reg.sv ====
module id_pipe_reg (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           instr_valid_i,   // fetch strobe
  input  id_pkg::instr_t instr_rdata_i,
  input  logic           deassert_we_i,   // stall, hold contents
  output id_pkg::instr_t instr_o,
  output logic           valid_o
);

  id_pkg::instr_t instr_q;
  logic           valid_q;

  // if/id register
  // a strobe always loads, otherwise stall holds and idle consumes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      instr_q <= '0;                 // opcode 0 decodes to nothing
      valid_q <= 1'b0;
    end else if (instr_valid_i) begin
      instr_q <= instr_rdata_i;
      valid_q <= 1'b1;
    end else if (!deassert_we_i) begin
      valid_q <= 1'b0;               // word consumed, no new one
    end
  end

  assign instr_o = instr_q;
  assign valid_o = valid_q;

endmodule

// ==== source/id_pkg.sv ====
package id_pkg;

  //////////////////////////////
  // decode stage vector types
  //////////////////////////////

  // raw rv32i instruction word, no compressed forms
  typedef logic [31:0] instr_t;

  // alu operator code, see ID_ALU_* macros
  typedef logic [5:0] alu_op_t;

  // operand a/b mux select
  typedef logic [2:0] op_sel_t;

  // immediate b mux select
  typedef logic [3:0] imm_sel_t;

  // word / half / byte
  typedef logic [1:0] data_type_t;

endpackage

// ==== source/id_stage.sv ====
module id_stage (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               instr_valid_i,
  input  id_pkg::instr_t     instr_rdata_i,
  input  logic               deassert_we_i,
  input  logic               jump_mux_i,
  input  logic               branch_mux_i,
  output logic               illegal_insn_o,
  output logic               ebrk_insn_o,
  output logic               mret_insn_o,
  output logic               ecall_insn_o,
  output logic               pipe_flush_o,
  output id_pkg::alu_op_t    alu_operator_o,
  output id_pkg::op_sel_t    alu_op_a_mux_sel_o,
  output id_pkg::op_sel_t    alu_op_b_mux_sel_o,
  output id_pkg::imm_sel_t   imm_b_mux_sel_o,
  output logic               regfile_we_o,
  output logic               data_req_o,
  output logic               data_we_o,
  output id_pkg::data_type_t data_type_o,
  output logic               data_sign_extension_o,
  output logic               jump_in_id_o,
  output logic               branch_in_id_o
);

  id_pkg::instr_t   id_instr;
  logic             id_valid;

  // alu decoder verdicts
  logic             alu_hit, alu_illegal, alu_we, alu_jump, alu_branch;
  id_pkg::op_sel_t  alu_op_b_sel;
  id_pkg::imm_sel_t alu_imm_b_sel;

  // lsu decoder verdicts
  logic             lsu_hit, lsu_illegal, lsu_we, lsu_req, lsu_data_we;
  id_pkg::imm_sel_t lsu_imm_b_sel;

  // sys decoder verdicts
  logic             sys_hit, sys_illegal, sys_ecall, sys_ebrk, sys_mret, sys_flush;

  id_pipe_reg i_pipe_reg (
    .clk_i, .rst_n_i, .instr_valid_i, .instr_rdata_i, .deassert_we_i,
    .instr_o (id_instr), .valid_o (id_valid)
  );

  alu_decoder i_alu_dec (
    .instr_i (id_instr), .jump_mux_i, .branch_mux_i, .alu_operator_o, .alu_op_a_mux_sel_o,
    .alu_op_b_mux_sel_o (alu_op_b_sel), .imm_b_mux_sel_o (alu_imm_b_sel),
    .regfile_we_o (alu_we), .jump_o (alu_jump), .branch_o (alu_branch),
    .hit_o (alu_hit), .illegal_o (alu_illegal)
  );

  lsu_decoder i_lsu_dec (
    .instr_i (id_instr), .data_req_o (lsu_req), .data_we_o (lsu_data_we),
    .data_sign_extension_o, .regfile_we_o (lsu_we), .hit_o (lsu_hit),
    .illegal_o (lsu_illegal), .data_type_o, .imm_b_mux_sel_o (lsu_imm_b_sel)
  );

  sys_decoder i_sys_dec (
    .instr_i (id_instr), .ecall_o (sys_ecall), .ebrk_o (sys_ebrk), .mret_o (sys_mret),
    .pipe_flush_o (sys_flush), .hit_o (sys_hit), .illegal_o (sys_illegal)
  );

  id_ctrl_gate i_ctrl_gate (
    .valid_i (id_valid), .deassert_we_i,
    .alu_hit_i (alu_hit), .alu_illegal_i (alu_illegal),
    .lsu_hit_i (lsu_hit), .lsu_illegal_i (lsu_illegal),
    .sys_hit_i (sys_hit), .sys_illegal_i (sys_illegal),
    .alu_regfile_we_i (alu_we), .lsu_regfile_we_i (lsu_we),
    .data_req_i (lsu_req), .data_we_i (lsu_data_we),
    .jump_i (alu_jump), .branch_i (alu_branch),
    .ecall_i (sys_ecall), .ebrk_i (sys_ebrk), .mret_i (sys_mret), .pipe_flush_i (sys_flush),
    .alu_op_b_sel_i (alu_op_b_sel), .alu_imm_b_sel_i (alu_imm_b_sel),
    .lsu_imm_b_sel_i (lsu_imm_b_sel),
    .illegal_insn_o, .regfile_we_o, .data_req_o, .data_we_o, .jump_in_id_o,
    .branch_in_id_o, .ecall_insn_o, .ebrk_insn_o, .mret_insn_o, .pipe_flush_o,
    .alu_op_b_mux_sel_o, .imm_b_mux_sel_o
  );

endmodule

// ==== source/lsu_decoder.sv ====
`include "id_defs.svh"

module lsu_decoder (
  input  id_pkg::instr_t     instr_i,
  output logic               data_req_o,
  output logic               data_we_o,
  output logic               data_sign_extension_o,
  output logic               regfile_we_o,
  output logic               hit_o,
  output logic               illegal_o,
  output id_pkg::data_type_t data_type_o,
  output id_pkg::imm_sel_t   imm_b_mux_sel_o   // address offset
);

  logic       is_load;
  logic       is_store;
  logic [2:0] funct3;

  assign funct3   = instr_i[`ID_F3_RANGE];
  assign is_load  = (instr_i[`ID_OPC_RANGE] == `ID_OPC_LOAD);
  assign is_store = (instr_i[`ID_OPC_RANGE] == `ID_OPC_STORE);

  assign hit_o           = is_load | is_store;
  assign data_req_o      = hit_o;
  assign data_we_o       = is_store;
  assign regfile_we_o    = is_load;
  assign imm_b_mux_sel_o = (is_store) ? `ID_IMMB_S : `ID_IMMB_I;

  // lbu/lhu clear bit 2, stores never extend
  assign data_sign_extension_o = is_load & ~funct3[2];

  always_comb begin
    case (funct3[1:0])
      2'b00:   data_type_o = `ID_DT_BYTE;
      2'b01:   data_type_o = `ID_DT_HALF;
      default: data_type_o = `ID_DT_WORD;   // 11 flagged below
    endcase
  end

  // size 11, no lwu, no unsigned store forms
  assign illegal_o = hit_o & ((funct3[1:0] == 2'b11) |
                              (is_load & (funct3[2:1] == 2'b11)) |
                              (is_store & funct3[2]));

endmodule

// ==== source/sys_decoder.sv ====
`include "id_defs.svh"

module sys_decoder (
  input  id_pkg::instr_t instr_i,
  output logic           ecall_o,
  output logic           ebrk_o,
  output logic           mret_o,
  output logic           pipe_flush_o,   // wfi, fence.i
  output logic           hit_o,
  output logic           illegal_o
);

  logic [2:0] funct3;

  assign funct3 = instr_i[`ID_F3_RANGE];

  always_comb begin
    ecall_o      = 1'b0;
    ebrk_o       = 1'b0;
    mret_o       = 1'b0;
    pipe_flush_o = 1'b0;
    hit_o        = 1'b1;
    illegal_o    = 1'b0;

    case (instr_i[`ID_OPC_RANGE])
      `ID_OPC_SYSTEM: begin
        if (funct3 != 3'b000) begin
          illegal_o = 1'b1;          // csr ops not supported
        end else begin
          case (instr_i[`ID_F12_RANGE])
            `ID_SYS_ECALL:  ecall_o      = 1'b1;
            `ID_SYS_EBREAK: ebrk_o       = 1'b1;
            `ID_SYS_MRET:   mret_o       = 1'b1;
            `ID_SYS_WFI:    pipe_flush_o = 1'b1;
            default:        illegal_o    = 1'b1;
          endcase
        end
      end
      `ID_OPC_FENCE: begin
        case (funct3)
          3'b000:  ;                     // fence, nothing to order here
          3'b001:  pipe_flush_o = 1'b1;  // fence.i refetch
          default: illegal_o    = 1'b1;
        endcase
      end
      default: hit_o = 1'b0;
    endcase
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/id_pkg.sv
source/id_pipe_reg.sv
source/alu_decoder.sv
source/lsu_decoder.sv
source/sys_decoder.sv
source/id_ctrl_gate.sv
source/id_stage.sv
bench/tb_clk_gen.sv
bench/tb_id_stage.sv
